// File: mmu_pkg.sv
package mmu_pkg;

  // Sv39 virtual page number
  // Three levels of 9 bits each
  localparam int unsigned VPN_W = 27;

  // One level segment of the VPN
  localparam int unsigned VPN_SEG_W = 9;

  // Sv39 physical page number
  localparam int unsigned PPN_W = 44;

  // L2 TLB geometry
  localparam int unsigned L2_ENTRIES = 8;

  // Entry index and replacement pointer width
  localparam int unsigned IDX_W = $clog2(L2_ENTRIES);

  // Page size of a translation
  // 2M passes VPN[8:0] into the PPN
  // 1G passes VPN[17:0] into the PPN
  typedef enum logic [1:0] {
    PAGE_4K = 2'd0,
    PAGE_2M = 2'd1,
    PAGE_1G = 2'd2
  } page_type_e;

  // Which L1 TLB a transaction belongs to
  typedef enum logic {
    ITLB = 1'b0,
    DTLB = 1'b1
  } tlb_origin_e;

  // PTE permission and status bits
  // Only carried, never checked here
  typedef struct packed {
    logic r;
    logic w;
    logic x;
    logic d;
    logic g;
    logic u;
  } pte_flags_t;

  // One L2 TLB load from the fill port
  // 27 + 44 + 2 + 6 = 79 bits
  typedef struct packed {
    logic [VPN_W-1:0] vpn;
    logic [PPN_W-1:0] ppn;
    page_type_e       page_type;
    pte_flags_t       flags;
  } tlb_fill_t;

endpackage

// File: tlb_req_if.sv
`timescale 1ns/100ps

interface tlb_req_if import mmu_pkg::*; ();

  // Handshake
  logic        valid;
  logic        ready;

  // Payload
  logic [VPN_W-1:0] vpn;
  tlb_origin_e      origin;

  // L1 side or arbiter toward L2
  modport requester (
    output valid,
    output vpn,
    output origin,
    input  ready
  );

  // Arbiter toward L1 or L2 TLB
  modport server (
    input  valid,
    input  vpn,
    input  origin,
    output ready
  );

endinterface

// File: tlb_ans_if.sv
`timescale 1ns/100ps

interface tlb_ans_if import mmu_pkg::*; ();

  // Handshake
  logic             valid;
  logic             ready;

  // Routing and payload
  tlb_origin_e      destination;
  logic [VPN_W-1:0] vpn;
  logic [PPN_W-1:0] ppn;
  page_type_e       page_type;
  pte_flags_t       flags;
  logic             exception;

  // L2 TLB answer slot
  modport sender (
    output valid,
    output destination,
    output vpn,
    output ppn,
    output page_type,
    output flags,
    output exception,
    input  ready
  );

  // Arbiter answer dispatcher
  modport receiver (
    input  valid,
    input  destination,
    input  vpn,
    input  ppn,
    input  page_type,
    input  flags,
    input  exception,
    output ready
  );

endinterface

// File: tlb_arbiter.sv
`timescale 1ns/100ps

module tlb_arbiter import mmu_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  // L1 request channels
  tlb_req_if.server          itlb_req_i,
  tlb_req_if.server          dtlb_req_i,
  // Single request channel toward L2
  tlb_req_if.requester       l2_req_o,
  // Answer channel from L2
  tlb_ans_if.receiver        l2_ans_i,
  // Per-side answer valids
  output logic               itlb_ans_valid_o,
  output logic               dtlb_ans_valid_o,
  // Per-side answer readies
  input  logic               itlb_ans_rdy_i,
  input  logic               dtlb_ans_rdy_i
);

  // Tie winner toggle
  tlb_origin_e tie_winner_q;

  // Request side decode
  logic any_req;
  logic is_tie;
  logic sel_dtlb;
  logic tie_resolved;

  // Both sides asking in the same cycle
  assign is_tie  = itlb_req_i.valid & dtlb_req_i.valid;
  assign any_req = itlb_req_i.valid | dtlb_req_i.valid;

  // Lone requester wins outright
  // On a tie the toggle decides
  always_comb begin
    if (is_tie) begin
      sel_dtlb = (tie_winner_q == DTLB);
    end else begin
      sel_dtlb = dtlb_req_i.valid;
    end
  end

  // Forward the chosen request
  assign l2_req_o.valid  = any_req;
  assign l2_req_o.vpn    = sel_dtlb ? dtlb_req_i.vpn : itlb_req_i.vpn;
  assign l2_req_o.origin = sel_dtlb ? dtlb_req_i.origin : itlb_req_i.origin;

  // L2 ready goes back only to the winner
  // Loser and idle sides see ready low
  assign itlb_req_i.ready = itlb_req_i.valid & ~sel_dtlb & l2_req_o.ready;
  assign dtlb_req_i.ready = dtlb_req_i.valid &  sel_dtlb & l2_req_o.ready;

  // Tie counts as served only when L2 takes it
  assign tie_resolved = is_tie & l2_req_o.ready;

  // Flip the tie winner after each served tie
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tie_winner_q <= ITLB;
    end else if (tie_resolved) begin
      tie_winner_q <= (tie_winner_q == ITLB) ? DTLB : ITLB;
    end
  end

  // Answer valid steered by destination
  assign itlb_ans_valid_o = l2_ans_i.valid & (l2_ans_i.destination == ITLB);
  assign dtlb_ans_valid_o = l2_ans_i.valid & (l2_ans_i.destination == DTLB);

  // Ready from the addressed L1 only
  assign l2_ans_i.ready = (l2_ans_i.destination == ITLB) ? itlb_ans_rdy_i : dtlb_ans_rdy_i;

endmodule

// File: l2_tlb.sv
`timescale 1ns/100ps

module l2_tlb import mmu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Lookup request from the arbiter
  tlb_req_if.server  req_i,
  // Registered answer slot
  tlb_ans_if.sender  ans_o,
  // Fill and flush
  input  logic       fill_valid_i,
  input  tlb_fill_t  fill_i,
  input  logic       flush_i
);

  // VPN bits that take part in the compare for a page size
  function automatic logic [VPN_W-1:0] vpn_keep_mask(page_type_e pt);
    logic [VPN_W-1:0] mask;
    unique case (pt)
      PAGE_2M: mask = {VPN_W{1'b1}} << VPN_SEG_W;
      PAGE_1G: mask = {VPN_W{1'b1}} << (2 * VPN_SEG_W);
      default: mask = {VPN_W{1'b1}};
    endcase
    return mask;
  endfunction

  // Entry array
  logic [L2_ENTRIES-1:0] entry_valid_q;
  logic [VPN_W-1:0]      entry_vpn_q   [L2_ENTRIES];
  logic [PPN_W-1:0]      entry_ppn_q   [L2_ENTRIES];
  page_type_e            entry_type_q  [L2_ENTRIES];
  pte_flags_t            entry_flags_q [L2_ENTRIES];

  // Round-robin victim
  logic [IDX_W-1:0]      repl_ptr_q;

  // Lookup
  logic [L2_ENTRIES-1:0] hit_vec;
  logic                  lookup_hit;
  logic [IDX_W-1:0]      lookup_idx;
  logic [PPN_W-1:0]      ppn_keep;
  logic [PPN_W-1:0]      lookup_ppn;

  // Fill target
  logic [L2_ENTRIES-1:0] fill_hit_vec;
  logic                  fill_hit;
  logic [IDX_W-1:0]      fill_idx;
  logic [IDX_W-1:0]      wr_idx;

  // Answer slot
  logic                  ans_valid_q;
  tlb_origin_e           ans_dest_q;
  logic [VPN_W-1:0]      ans_vpn_q;
  logic [PPN_W-1:0]      ans_ppn_q;
  page_type_e            ans_type_q;
  pte_flags_t            ans_flags_q;
  logic                  ans_exc_q;

  // Masked compare per entry
  // Also finds an exact match for the fill
  always_comb begin
    for (int i = 0; i < L2_ENTRIES; i++) begin
      hit_vec[i] = entry_valid_q[i] &&
                   (((entry_vpn_q[i] ^ req_i.vpn) & vpn_keep_mask(entry_type_q[i])) == '0);
      fill_hit_vec[i] = entry_valid_q[i] && (entry_vpn_q[i] == fill_i.vpn) &&
                        (entry_type_q[i] == fill_i.page_type);
    end
  end

  // Lowest matching index wins
  always_comb begin
    lookup_idx = '0;
    fill_idx   = '0;
    for (int i = L2_ENTRIES - 1; i >= 0; i--) begin
      if (hit_vec[i]) begin
        lookup_idx = IDX_W'(i);
      end
      if (fill_hit_vec[i]) begin
        fill_idx = IDX_W'(i);
      end
    end
  end

  assign lookup_hit = |hit_vec;
  assign fill_hit   = |fill_hit_vec;

  // Upper PPN from the entry, low segments from the request
  assign ppn_keep   = {{(PPN_W - VPN_W){1'b1}}, vpn_keep_mask(entry_type_q[lookup_idx])};
  assign lookup_ppn = (entry_ppn_q[lookup_idx] & ppn_keep) |
                      ({{(PPN_W - VPN_W){1'b0}}, req_i.vpn} & ~ppn_keep);

  // Overwrite a matching entry, else take the victim
  assign wr_idx = fill_hit ? fill_idx : repl_ptr_q;

  // Valid bits and replacement pointer
  // Flush beats a fill on the same edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      entry_valid_q <= '0;
      repl_ptr_q    <= '0;
    end else if (flush_i) begin
      entry_valid_q <= '0;
    end else if (fill_valid_i) begin
      entry_valid_q[wr_idx] <= 1'b1;
      if (!fill_hit) begin
        repl_ptr_q <= repl_ptr_q + IDX_W'(1);
      end
    end
  end

  // Entry payload
  always_ff @(posedge clk_i) begin
    if (fill_valid_i && !flush_i) begin
      entry_vpn_q[wr_idx]   <= fill_i.vpn;
      entry_ppn_q[wr_idx]   <= fill_i.ppn;
      entry_type_q[wr_idx]  <= fill_i.page_type;
      entry_flags_q[wr_idx] <= fill_i.flags;
    end
  end

  // Accept only into an empty slot
  assign req_i.ready = ~ans_valid_q;

  // Slot occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ans_valid_q <= 1'b0;
    end else if (req_i.valid && req_i.ready) begin
      ans_valid_q <= 1'b1;
    end else if (ans_o.valid && ans_o.ready) begin
      ans_valid_q <= 1'b0;
    end
  end

  // Capture the lookup result
  // Miss gives exception with zero PPN and flags
  always_ff @(posedge clk_i) begin
    if (req_i.valid && req_i.ready) begin
      ans_dest_q  <= req_i.origin;
      ans_vpn_q   <= req_i.vpn;
      ans_ppn_q   <= lookup_hit ? lookup_ppn : '0;
      ans_type_q  <= lookup_hit ? entry_type_q[lookup_idx] : PAGE_4K;
      ans_flags_q <= lookup_hit ? entry_flags_q[lookup_idx] : '0;
      ans_exc_q   <= ~lookup_hit;
    end
  end

  // Slot drives the answer channel
  assign ans_o.valid       = ans_valid_q;
  assign ans_o.destination = ans_dest_q;
  assign ans_o.vpn         = ans_vpn_q;
  assign ans_o.ppn         = ans_ppn_q;
  assign ans_o.page_type   = ans_type_q;
  assign ans_o.flags       = ans_flags_q;
  assign ans_o.exception   = ans_exc_q;

endmodule

// File: l2_tlb_subsys.sv
`timescale 1ns/100ps

module l2_tlb_subsys import mmu_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  // I-TLB request
  input  logic             itlb_req_valid_i,
  input  logic [VPN_W-1:0] itlb_req_vpn_i,
  output logic             itlb_req_rdy_o,
  // D-TLB request
  input  logic             dtlb_req_valid_i,
  input  logic [VPN_W-1:0] dtlb_req_vpn_i,
  output logic             dtlb_req_rdy_o,
  // I-TLB answer
  output logic             itlb_ans_valid_o,
  output logic [PPN_W-1:0] itlb_ans_ppn_o,
  output page_type_e       itlb_ans_page_type_o,
  output logic             itlb_ans_g_o,
  output logic             itlb_ans_u_o,
  output logic             itlb_ans_exception_o,
  input  logic             itlb_ans_rdy_i,
  // D-TLB answer
  output logic             dtlb_ans_valid_o,
  output logic [VPN_W-1:0] dtlb_ans_vpn_o,
  output logic [PPN_W-1:0] dtlb_ans_ppn_o,
  output page_type_e       dtlb_ans_page_type_o,
  output pte_flags_t       dtlb_ans_flags_o,
  output logic             dtlb_ans_exception_o,
  input  logic             dtlb_ans_rdy_i,
  // Fill and flush
  input  logic             fill_valid_i,
  input  tlb_fill_t        fill_i,
  input  logic             flush_i
);

  // Channels inside the subsystem
  tlb_req_if itlb_req ();
  tlb_req_if dtlb_req ();
  tlb_req_if l2_req ();
  tlb_ans_if l2_ans ();

  // I-TLB side request, origin fixed
  assign itlb_req.valid  = itlb_req_valid_i;
  assign itlb_req.vpn    = itlb_req_vpn_i;
  assign itlb_req.origin = ITLB;
  assign itlb_req_rdy_o  = itlb_req.ready;

  // D-TLB side request, origin fixed
  assign dtlb_req.valid  = dtlb_req_valid_i;
  assign dtlb_req.vpn    = dtlb_req_vpn_i;
  assign dtlb_req.origin = DTLB;
  assign dtlb_req_rdy_o  = dtlb_req.ready;

  // Scheduler and answer dispatcher
  tlb_arbiter i_tlb_arbiter (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .itlb_req_i       (itlb_req),
    .dtlb_req_i       (dtlb_req),
    .l2_req_o         (l2_req),
    .l2_ans_i         (l2_ans),
    .itlb_ans_valid_o (itlb_ans_valid_o),
    .dtlb_ans_valid_o (dtlb_ans_valid_o),
    .itlb_ans_rdy_i   (itlb_ans_rdy_i),
    .dtlb_ans_rdy_i   (dtlb_ans_rdy_i)
  );

  // Shared translation store
  l2_tlb i_l2_tlb (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (l2_req),
    .ans_o        (l2_ans),
    .fill_valid_i (fill_valid_i),
    .fill_i       (fill_i),
    .flush_i      (flush_i)
  );

  // I-TLB view of the answer
  assign itlb_ans_ppn_o       = l2_ans.ppn;
  assign itlb_ans_page_type_o = l2_ans.page_type;
  assign itlb_ans_g_o         = l2_ans.flags.g;
  assign itlb_ans_u_o         = l2_ans.flags.u;
  assign itlb_ans_exception_o = l2_ans.exception;

  // D-TLB view also gets VPN and all flags
  assign dtlb_ans_vpn_o       = l2_ans.vpn;
  assign dtlb_ans_ppn_o       = l2_ans.ppn;
  assign dtlb_ans_page_type_o = l2_ans.page_type;
  assign dtlb_ans_flags_o     = l2_ans.flags;
  assign dtlb_ans_exception_o = l2_ans.exception;

endmodule

// File: l2_tlb_subsys_assertions.sv
`timescale 1ns/100ps

module l2_tlb_subsys_assertions import mmu_pkg::*; (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             itlb_req_rdy_i,
  input logic             dtlb_req_rdy_i,
  input logic             itlb_ans_valid_i,
  input logic             dtlb_ans_valid_i,
  input logic             itlb_ans_rdy_i,
  input logic             dtlb_ans_rdy_i,
  input logic [VPN_W-1:0] ans_vpn_i,
  input logic [PPN_W-1:0] ans_ppn_i,
  input page_type_e       ans_page_type_i,
  input pte_flags_t       ans_flags_i,
  input logic             ans_exception_i
);

  // Only one L1 side may be granted
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(itlb_req_rdy_i && dtlb_req_rdy_i))
    else $error("Both L1 request readies high");

  // One destination per answer
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(itlb_ans_valid_i && dtlb_ans_valid_i))
    else $error("Both answer valids high");

  // Held answer keeps its side and payload
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (itlb_ans_valid_i && !itlb_ans_rdy_i) || (dtlb_ans_valid_i && !dtlb_ans_rdy_i) |=>
    $stable(itlb_ans_valid_i) && $stable(dtlb_ans_valid_i) && $stable(ans_vpn_i) &&
    $stable(ans_ppn_i) && $stable(ans_page_type_i) && $stable(ans_flags_i) &&
    $stable(ans_exception_i))
    else $error("Answer changed before ready");

endmodule

bind l2_tlb_subsys l2_tlb_subsys_assertions i_l2_tlb_subsys_assertions (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .itlb_req_rdy_i   (itlb_req_rdy_o),
  .dtlb_req_rdy_i   (dtlb_req_rdy_o),
  .itlb_ans_valid_i (itlb_ans_valid_o),
  .dtlb_ans_valid_i (dtlb_ans_valid_o),
  .itlb_ans_rdy_i   (itlb_ans_rdy_i),
  .dtlb_ans_rdy_i   (dtlb_ans_rdy_i),
  .ans_vpn_i        (dtlb_ans_vpn_o),
  .ans_ppn_i        (dtlb_ans_ppn_o),
  .ans_page_type_i  (dtlb_ans_page_type_o),
  .ans_flags_i      (dtlb_ans_flags_o),
  .ans_exception_i  (dtlb_ans_exception_o)
);

// File: tb_l2_tlb_subsys.sv
`timescale 1ns/100ps

module tb_l2_tlb_subsys import mmu_pkg::*; ();

  // Rough length of all tests in cycles
  localparam int unsigned TEST_CYCLES = 200;

  logic             clk_i;
  logic             rst_ni;
  logic             itlb_req_valid_i;
  logic [VPN_W-1:0] itlb_req_vpn_i;
  logic             itlb_req_rdy_o;
  logic             dtlb_req_valid_i;
  logic [VPN_W-1:0] dtlb_req_vpn_i;
  logic             dtlb_req_rdy_o;
  logic             itlb_ans_valid_o;
  logic [PPN_W-1:0] itlb_ans_ppn_o;
  page_type_e       itlb_ans_page_type_o;
  logic             itlb_ans_g_o;
  logic             itlb_ans_u_o;
  logic             itlb_ans_exception_o;
  logic             itlb_ans_rdy_i;
  logic             dtlb_ans_valid_o;
  logic [VPN_W-1:0] dtlb_ans_vpn_o;
  logic [PPN_W-1:0] dtlb_ans_ppn_o;
  page_type_e       dtlb_ans_page_type_o;
  pte_flags_t       dtlb_ans_flags_o;
  logic             dtlb_ans_exception_o;
  logic             dtlb_ans_rdy_i;
  logic             fill_valid_i;
  tlb_fill_t        fill_i;
  logic             flush_i;

  // Reference model of the entry array
  logic             model_valid [L2_ENTRIES];
  logic [VPN_W-1:0] model_vpn   [L2_ENTRIES];
  logic [PPN_W-1:0] model_ppn   [L2_ENTRIES];
  page_type_e       model_type  [L2_ENTRIES];
  pte_flags_t       model_flags [L2_ENTRIES];
  int unsigned      model_ptr;
  // Expected winner of the next tie
  tlb_origin_e      tie_exp;
  int unsigned      seed_val;

  l2_tlb_subsys i_l2_tlb_subsys (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("FAIL at %0t: %s got %0h expected %0h", $time, name, actual, expected);
      report_failure("Value mismatch");
    end
  endtask

  function automatic logic [VPN_W-1:0] rand_vpn();
    return VPN_W'($urandom);
  endfunction

  // Count of low VPN bits copied into the PPN
  function automatic int unsigned passthru_bits(input page_type_e pt);
    if (pt == PAGE_1G) return 2 * VPN_SEG_W;
    if (pt == PAGE_2M) return VPN_SEG_W;
    return 0;
  endfunction

  task automatic predict(input logic [VPN_W-1:0] vpn, output logic hit,
                         output logic [PPN_W-1:0] ppn, output page_type_e pt,
                         output pte_flags_t fl);
    int unsigned n;
    hit = 1'b0;
    ppn = '0;
    pt  = PAGE_4K;
    fl  = '0;
    for (int i = 0; i < L2_ENTRIES; i++) begin
      n = passthru_bits(model_type[i]);
      if (!hit && model_valid[i] && ((model_vpn[i] >> n) == (vpn >> n))) begin
        hit = 1'b1;
        ppn = ((model_ppn[i] >> n) << n) | PPN_W'(vpn & VPN_W'((1 << n) - 1));
        pt  = model_type[i];
        fl  = model_flags[i];
      end
    end
  endtask

  // Exact match overwrites, else round-robin victim
  task automatic fill_entry(input logic [VPN_W-1:0] vpn, input logic [PPN_W-1:0] ppn,
                            input page_type_e pt, input pte_flags_t fl);
    int slot;
    slot = -1;
    for (int i = 0; i < L2_ENTRIES; i++) begin
      if (slot < 0 && model_valid[i] && model_vpn[i] == vpn && model_type[i] == pt) begin
        slot = i;
      end
    end
    if (slot < 0) begin
      slot      = model_ptr;
      model_ptr = (model_ptr + 1) % L2_ENTRIES;
    end
    @(posedge clk_i);
    fill_valid_i <= 1'b1;
    fill_i       <= {vpn, ppn, pt, fl};
    @(posedge clk_i);
    fill_valid_i      <= 1'b0;
    model_valid[slot] = 1'b1;
    model_vpn[slot]   = vpn;
    model_ppn[slot]   = ppn;
    model_type[slot]  = pt;
    model_flags[slot] = fl;
  endtask

  task automatic flush_all();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    for (int i = 0; i < L2_ENTRIES; i++) begin
      model_valid[i] = 1'b0;
    end
  endtask

  task automatic raise_req(input tlb_origin_e side, input logic [VPN_W-1:0] vpn);
    if (side == ITLB) begin
      itlb_req_valid_i <= 1'b1;
      itlb_req_vpn_i   <= vpn;
    end else begin
      dtlb_req_valid_i <= 1'b1;
      dtlb_req_vpn_i   <= vpn;
    end
  endtask

  // Answer is checked one cycle after the transfer
  task automatic check_answer(input tlb_origin_e side, input logic [VPN_W-1:0] vpn,
                              output logic exc, output logic [PPN_W-1:0] ppn);
    logic             hit;
    logic [PPN_W-1:0] exp_ppn;
    page_type_e       exp_pt;
    pte_flags_t       exp_fl;
    predict(vpn, hit, exp_ppn, exp_pt, exp_fl);
    if (side == ITLB) begin
      check_value("itlb_ans_valid_o", itlb_ans_valid_o, 1'b1);
      check_value("dtlb_ans_valid_o", dtlb_ans_valid_o, 1'b0);
      check_value("itlb_ans_exception_o", itlb_ans_exception_o, !hit);
      check_value("itlb_ans_ppn_o", itlb_ans_ppn_o, exp_ppn);
      check_value("itlb_ans_g_o", itlb_ans_g_o, exp_fl.g);
      check_value("itlb_ans_u_o", itlb_ans_u_o, exp_fl.u);
      if (hit) check_value("itlb_ans_page_type_o", itlb_ans_page_type_o, exp_pt);
      exc = itlb_ans_exception_o;
      ppn = itlb_ans_ppn_o;
    end else begin
      check_value("dtlb_ans_valid_o", dtlb_ans_valid_o, 1'b1);
      check_value("itlb_ans_valid_o", itlb_ans_valid_o, 1'b0);
      check_value("dtlb_ans_exception_o", dtlb_ans_exception_o, !hit);
      check_value("dtlb_ans_vpn_o", dtlb_ans_vpn_o, vpn);
      check_value("dtlb_ans_ppn_o", dtlb_ans_ppn_o, exp_ppn);
      check_value("dtlb_ans_flags_o", dtlb_ans_flags_o, exp_fl);
      if (hit) check_value("dtlb_ans_page_type_o", dtlb_ans_page_type_o, exp_pt);
      exc = dtlb_ans_exception_o;
      ppn = dtlb_ans_ppn_o;
    end
  endtask

  // Wait for whichever raised request gets ready, then check its answer
  task automatic serve_pending(output tlb_origin_e side, output logic exc,
                               output logic [PPN_W-1:0] ppn);
    int unsigned      waited;
    logic [VPN_W-1:0] vpn;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > 20) report_failure("No request was accepted within 20 cycles");
    end while (!itlb_req_rdy_o && !dtlb_req_rdy_o);
    check_value("dtlb_req_rdy_o", itlb_req_rdy_o & dtlb_req_rdy_o, 1'b0);
    side = itlb_req_rdy_o ? ITLB : DTLB;
    vpn  = itlb_req_rdy_o ? itlb_req_vpn_i : dtlb_req_vpn_i;
    @(posedge clk_i);
    if (side == ITLB) itlb_req_valid_i <= 1'b0;
    else dtlb_req_valid_i <= 1'b0;
    @(negedge clk_i);
    check_answer(side, vpn, exc, ppn);
  endtask

  task automatic translate(input tlb_origin_e side, input logic [VPN_W-1:0] vpn,
                           output logic exc, output logic [PPN_W-1:0] ppn);
    tlb_origin_e got;
    @(posedge clk_i);
    raise_req(side, vpn);
    serve_pending(got, exc, ppn);
    check_value("served side", got, side);
  endtask

  task automatic tie_round(input logic [VPN_W-1:0] vpn_i, input logic [VPN_W-1:0] vpn_d);
    tlb_origin_e      first;
    tlb_origin_e      second;
    logic             exc;
    logic [PPN_W-1:0] ppn;
    @(posedge clk_i);
    raise_req(ITLB, vpn_i);
    raise_req(DTLB, vpn_d);
    serve_pending(first, exc, ppn);
    check_value("tie winner", first, tie_exp);
    tie_exp = (tie_exp == ITLB) ? DTLB : ITLB;
    serve_pending(second, exc, ppn);
    check_value("tie loser", second, (first == ITLB) ? DTLB : ITLB);
  endtask

  // Behaviors 1 and 2, then misses, flush and eviction
  task automatic test_hits_and_misses();
    logic             exc;
    logic [PPN_W-1:0] ppn;
    logic [VPN_W-1:0] v;
    logic [VPN_W-1:0] first_vpn;
    v = rand_vpn();
    fill_entry(v, PPN_W'({$urandom, $urandom}), PAGE_4K, 6'($urandom));
    translate(ITLB, v, exc, ppn);
    check_value("itlb_ans_exception_o", exc, 1'b0);
    translate(DTLB, v, exc, ppn);
    check_value("dtlb_ans_exception_o", exc, 1'b0);
    translate(ITLB, rand_vpn(), exc, ppn);
    check_value("itlb_ans_exception_o", exc, 1'b1);
    flush_all();
    translate(DTLB, v, exc, ppn);
    check_value("dtlb_ans_exception_o", exc, 1'b1);
    first_vpn = rand_vpn();
    fill_entry(first_vpn, PPN_W'({$urandom, $urandom}), PAGE_4K, 6'($urandom));
    for (int i = 0; i < L2_ENTRIES; i++) begin
      v = rand_vpn();
      fill_entry(v, PPN_W'({$urandom, $urandom}), PAGE_4K, 6'($urandom));
    end
    translate(DTLB, first_vpn, exc, ppn);
    check_value("dtlb_ans_exception_o", exc, 1'b1);
    translate(ITLB, v, exc, ppn);
    check_value("itlb_ans_exception_o", exc, 1'b0);
  endtask

  // Low segments of the PPN come from the request
  task automatic test_superpages();
    logic             exc;
    logic [PPN_W-1:0] ppn;
    logic [VPN_W-1:0] v;
    logic [VPN_W-1:0] req;
    v = rand_vpn();
    fill_entry(v, PPN_W'({$urandom, $urandom}), PAGE_2M, 6'($urandom));
    req = {v[VPN_W-1:VPN_SEG_W], VPN_SEG_W'($urandom)};
    translate(DTLB, req, exc, ppn);
    check_value("dtlb_ans_exception_o", exc, 1'b0);
    check_value("dtlb_ans_ppn_o low", ppn[VPN_SEG_W-1:0], req[VPN_SEG_W-1:0]);
    v = rand_vpn();
    fill_entry(v, PPN_W'({$urandom, $urandom}), PAGE_1G, 6'($urandom));
    req = {v[VPN_W-1:2*VPN_SEG_W], 18'($urandom)};
    translate(ITLB, req, exc, ppn);
    check_value("itlb_ans_exception_o", exc, 1'b0);
    check_value("itlb_ans_ppn_o low", ppn[2*VPN_SEG_W-1:0], req[2*VPN_SEG_W-1:0]);
  endtask

  // Lone D-TLB request between ties leaves the order alone
  task automatic test_tie_order();
    logic             exc;
    logic [PPN_W-1:0] ppn;
    tie_round(rand_vpn(), rand_vpn());
    translate(DTLB, rand_vpn(), exc, ppn);
    tie_round(rand_vpn(), rand_vpn());
    tie_round(rand_vpn(), rand_vpn());
  endtask

  task automatic test_backpressure();
    logic             exc;
    logic [PPN_W-1:0] held_ppn;
    logic [PPN_W-1:0] ppn;
    logic [VPN_W-1:0] v;
    tlb_origin_e      got;
    v = rand_vpn();
    fill_entry(v, PPN_W'({$urandom, $urandom}), PAGE_4K, 6'($urandom));
    @(posedge clk_i);
    itlb_ans_rdy_i <= 1'b0;
    translate(ITLB, v, exc, held_ppn);
    // Both sides ask while the slot is blocked
    @(posedge clk_i);
    raise_req(DTLB, rand_vpn());
    raise_req(ITLB, rand_vpn());
    repeat (4) begin
      @(negedge clk_i);
      check_value("itlb_ans_valid_o", itlb_ans_valid_o, 1'b1);
      check_value("itlb_ans_ppn_o", itlb_ans_ppn_o, held_ppn);
      check_value("itlb_req_rdy_o", itlb_req_rdy_o, 1'b0);
      check_value("dtlb_req_rdy_o", dtlb_req_rdy_o, 1'b0);
    end
    @(posedge clk_i);
    itlb_ans_rdy_i <= 1'b1;
    // Stalled tie did not move the toggle, so the D-TLB goes first
    serve_pending(got, exc, ppn);
    check_value("served side", got, DTLB);
    serve_pending(got, exc, ppn);
    check_value("served side", got, ITLB);
  endtask

  initial begin
    seed_val         = $urandom(32'h92ea);
    rst_ni           = 1'b0;
    itlb_req_valid_i = 1'b0;
    itlb_req_vpn_i   = '0;
    dtlb_req_valid_i = 1'b0;
    dtlb_req_vpn_i   = '0;
    itlb_ans_rdy_i   = 1'b1;
    dtlb_ans_rdy_i   = 1'b1;
    fill_valid_i     = 1'b0;
    fill_i           = '0;
    flush_i          = 1'b0;
    for (int i = 0; i < L2_ENTRIES; i++) begin
      model_valid[i] = 1'b0;
    end
    model_ptr = 0;
    tie_exp   = ITLB;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_hits_and_misses();
    test_superpages();
    test_tie_order();
    test_backpressure();
    @(posedge clk_i);
    $display("Simulation passed");
    $finish;
  end

  // Twice the expected test length
  initial begin
    #(2 * TEST_CYCLES * 10);
    report_failure("Watchdog expired before the tests finished");
  end

endmodule

// File: l2_tlb_subsys.f
mmu_pkg.sv
tlb_req_if.sv
tlb_ans_if.sv
tlb_arbiter.sv
l2_tlb.sv
l2_tlb_subsys.sv
l2_tlb_subsys_assertions.sv
tb_l2_tlb_subsys.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the L2 TLB subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_l2_tlb_subsys -f l2_tlb_subsys.f

# A failing check stops the run with a nonzero status, the log decides
./obj_dir/Vtb_l2_tlb_subsys > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
